//--- verilog/earthrise_macros.svh
// Earthrise widths and constants
// word, coordinate, colour, command address, instruction fields, option bits
`ifndef EARTHRISE_MACROS_SVH
`define EARTHRISE_MACROS_SVH

`define ER_WORD        32  // machine word
`define ER_CORDW       12  // signed integer coordinate
`define ER_COLRW        8  // colour
`define ER_CMD_ADDRW    6  // command memory word address, pc is 2 bits wider
`define ER_VRAM_ADDRW  12  // pixel memory word address
`define ER_SHIFTW       3  // address shift

`define ER_INSTRW      16  // instruction
`define ER_OPCW         4  // opcode
`define ER_FUNW         4  // function
`define ER_IMM12       12  // wide immediate
`define ER_IMM8         8  // narrow immediate or options

`define ER_OPT_FILL     0  // filled shape
`define ER_OPT_COLR     1  // colour B instead of A
`define ER_WR_LAT       3  // cycles from drawing to memory write

`endif

//--- verilog/earthrise_pkg.sv
// Earthrise shared types: coordinates, colours, the two instruction views,
// opcode and draw function encodings, controller states
`include "earthrise_macros.svh"

package earthrise_pkg;

    typedef logic signed [`ER_CORDW-1:0] coord_t;  // integer pixel coordinate
    typedef logic [`ER_COLRW-1:0] colr_t;

    typedef enum logic [`ER_OPCW-1:0] {
        OP_X0   = 4'h0,  // vertex 0
        OP_Y0   = 4'h1,
        OP_X1   = 4'h2,  // vertex 1
        OP_Y1   = 4'h3,
        OP_XT   = 4'h8,  // translation
        OP_YT   = 4'h9,
        OP_JT   = 4'hA,  // jump target
        OP_CTRL = 4'hC,  // colours and flow
        OP_DRAW = 4'hD
    } opcode_t;

    typedef enum logic [`ER_FUNW-1:0] {
        DF_PIXEL = 4'h0,
        DF_LINE  = 4'h1,
        DF_RECT  = 4'h4,
        DF_FLINE = 4'hF  // horizontal span
    } drawfn_t;

    typedef struct packed {
        opcode_t opc;
        logic [`ER_IMM12-1:0] imm12;
    } instr_imm_t;

    typedef struct packed {
        opcode_t opc;
        logic [`ER_FUNW-1:0] fun;
        logic [`ER_IMM8-1:0] imm8;  // colour or option bits
    } instr_fn_t;

    typedef union packed {
        instr_imm_t imm;
        instr_fn_t fn;
    } instr_t;

    typedef enum logic [3:0] {
        IDLE, DONE, FETCH, DECODE, EXEC, JUMP_WAIT,
        LINE_EXEC, SPAN_EXEC, RECT_INIT, RECTF_INIT
    } er_state_t;

endpackage

//--- verilog/earthrise_ctrl.sv
// Earthrise controller: fetch, decode and execute of 16-bit instructions
// vertex, translation, jump and colour registers, shape sequencing
`timescale 1ns/1ps
`include "earthrise_macros.svh"

module earthrise_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic [`ER_WORD-1:0] cmd_list,
    input  logic line_valid,
    input  logic line_done,
    input  earthrise_pkg::coord_t line_x,
    input  earthrise_pkg::coord_t line_y,
    input  logic span_valid,
    input  logic span_done,
    input  earthrise_pkg::coord_t span_x,
    output logic [`ER_CMD_ADDRW+1:0] pc,
    output logic busy,
    output logic done,
    output logic instr_invalid,
    output logic line_start,
    output earthrise_pkg::coord_t line_x0,
    output earthrise_pkg::coord_t line_y0,
    output earthrise_pkg::coord_t line_x1,
    output earthrise_pkg::coord_t line_y1,
    output logic span_start,
    output earthrise_pkg::coord_t span_x0,
    output earthrise_pkg::coord_t span_x1,
    output logic drawing,
    output earthrise_pkg::coord_t x,
    output earthrise_pkg::coord_t y,
    output earthrise_pkg::colr_t colr
);
    import earthrise_pkg::*;

    localparam logic [`ER_CMD_ADDRW+1:0] PC_LAST = '1 << 1;  // last half-word

    er_state_t state, state_ret;
    instr_t instr;
    coord_t tvx0, tvy0, tvx1, tvy1;  // translated vertices
    coord_t xt, yt;
    coord_t rx0, ry0, rx1, ry1;      // rect corners, min and max
    coord_t cnt_fill;                // row offset for filled rect
    coord_t span_y;
    colr_t lca, lcb, fca, fcb;
    logic [`ER_CMD_ADDRW+1:0] pc_start;
    logic [1:0] cnt_draw;            // rect edge
    logic cmd_last;

    assign done = (state == DONE);

    always_ff @(posedge clk) begin
        drawing <= 1'b0;
        case (state)
            IDLE: begin
                if (start) begin
                    state <= FETCH;
                    busy <= 1'b1;
                    instr_invalid <= 1'b0;
                end
            end
            JUMP_WAIT: state <= FETCH;  // memory needs a cycle for the new pc
            FETCH: state <= cmd_last ? DONE : DECODE;
            DECODE: begin
                state <= EXEC;
                instr <= pc[1] ? cmd_list[2*`ER_INSTRW-1:`ER_INSTRW] : cmd_list[`ER_INSTRW-1:0];
                pc <= pc + 2'd2;
                if (pc == PC_LAST) cmd_last <= 1'b1;
                cnt_draw <= '0;
                cnt_fill <= '0;
            end
            EXEC: begin
                state <= FETCH;
                case (instr.imm.opc)
                    OP_X0: tvx0 <= coord_t'(instr.imm.imm12) + xt;
                    OP_Y0: tvy0 <= coord_t'(instr.imm.imm12) + yt;
                    OP_X1: tvx1 <= coord_t'(instr.imm.imm12) + xt;
                    OP_Y1: tvy1 <= coord_t'(instr.imm.imm12) + yt;
                    OP_XT: xt <= coord_t'(instr.imm.imm12);
                    OP_YT: yt <= coord_t'(instr.imm.imm12);
                    OP_JT: pc_start <= instr.imm.imm12[`ER_CMD_ADDRW+1:0];
                    OP_CTRL: begin
                        case (instr.fn.fun)
                            4'h0: lca <= instr.fn.imm8;
                            4'h1: lcb <= instr.fn.imm8;
                            4'h2: fca <= instr.fn.imm8;
                            4'h3: fcb <= instr.fn.imm8;
                            4'hA: begin  // change address
                                state <= JUMP_WAIT;
                                pc <= pc_start;
                                cmd_last <= 1'b0;
                            end
                            4'hC: state <= FETCH;  // continue
                            4'hE: state <= DONE;   // cease
                            default: begin
                                state <= DONE;
                                instr_invalid <= 1'b1;
                            end
                        endcase
                    end
                    OP_DRAW: begin
                        // fill colours for filled shapes, line colours otherwise
                        if (instr.fn.imm8[`ER_OPT_FILL])
                            colr <= instr.fn.imm8[`ER_OPT_COLR] ? fcb : fca;
                        else
                            colr <= instr.fn.imm8[`ER_OPT_COLR] ? lcb : lca;
                        case (instr.fn.fun)
                            DF_PIXEL: begin
                                x <= tvx0;
                                y <= tvy0;
                                drawing <= 1'b1;
                            end
                            DF_LINE: begin
                                state <= LINE_EXEC;
                                state_ret <= FETCH;
                                line_start <= 1'b1;
                                line_x0 <= tvx0;
                                line_y0 <= tvy0;
                                line_x1 <= tvx1;
                                line_y1 <= tvy1;
                            end
                            DF_RECT: begin
                                rx0 <= (tvx0 < tvx1) ? tvx0 : tvx1;
                                ry0 <= (tvy0 < tvy1) ? tvy0 : tvy1;
                                rx1 <= (tvx0 < tvx1) ? tvx1 : tvx0;
                                ry1 <= (tvy0 < tvy1) ? tvy1 : tvy0;
                                state <= instr.fn.imm8[`ER_OPT_FILL] ? RECTF_INIT : RECT_INIT;
                            end
                            DF_FLINE: begin
                                state <= SPAN_EXEC;
                                state_ret <= FETCH;
                                span_start <= 1'b1;
                                span_x0 <= tvx0;
                                span_x1 <= tvx1;
                                span_y <= tvy0;  // row from vertex 0
                            end
                            default: begin
                                state <= DONE;
                                instr_invalid <= 1'b1;
                            end
                        endcase
                    end
                    default: begin
                        state <= DONE;
                        instr_invalid <= 1'b1;
                    end
                endcase
            end
            RECT_INIT: begin  // edges: top, bottom, left, right
                state <= LINE_EXEC;
                state_ret <= (cnt_draw == 2'd3) ? FETCH : RECT_INIT;
                line_start <= 1'b1;
                line_x0 <= (cnt_draw == 2'd3) ? rx1 : rx0;
                line_x1 <= (cnt_draw == 2'd2) ? rx0 : rx1;
                line_y0 <= (cnt_draw == 2'd1) ? ry1 : ry0;
                line_y1 <= (cnt_draw == 2'd0) ? ry0 : ry1;
                cnt_draw <= cnt_draw + 2'd1;
            end
            RECTF_INIT: begin  // one span per row
                state <= SPAN_EXEC;
                state_ret <= (ry0 + cnt_fill < ry1) ? RECTF_INIT : FETCH;
                span_start <= 1'b1;
                span_x0 <= rx0;
                span_x1 <= rx1;
                span_y <= ry0 + cnt_fill;
                cnt_fill <= cnt_fill + coord_t'(1);
            end
            LINE_EXEC: begin
                if (line_done) state <= state_ret;
                line_start <= 1'b0;
                drawing <= line_valid;
                x <= line_x;
                y <= line_y;
            end
            SPAN_EXEC: begin
                if (span_done) state <= state_ret;
                span_start <= 1'b0;
                drawing <= span_valid;
                x <= span_x;
                y <= span_y;
            end
            DONE: begin
                state <= IDLE;
                busy <= 1'b0;
                pc <= '0;  // every program runs from address 0
                cmd_last <= 1'b0;
            end
            default: state <= IDLE;
        endcase
        if (rst) begin
            state <= IDLE;
            state_ret <= IDLE;
            pc <= '0;
            pc_start <= '0;
            cmd_last <= 1'b0;
            busy <= 1'b0;
            instr_invalid <= 1'b0;
            drawing <= 1'b0;
            line_start <= 1'b0;
            span_start <= 1'b0;
            lca <= colr_t'(1);
            lcb <= colr_t'(1);
            fca <= colr_t'(1);
            fcb <= colr_t'(1);
            xt <= '0;
            yt <= '0;
        end
    end

endmodule

//--- verilog/line_draw.sv
// Bresenham line engine, one pixel per cycle
// start point, each step and end point are emitted once
`timescale 1ns/1ps
`include "earthrise_macros.svh"

module line_draw (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  earthrise_pkg::coord_t x0,
    input  earthrise_pkg::coord_t y0,
    input  earthrise_pkg::coord_t x1,
    input  earthrise_pkg::coord_t y1,
    output earthrise_pkg::coord_t x,
    output earthrise_pkg::coord_t y,
    output logic valid,
    output logic busy,
    output logic done
);
    import earthrise_pkg::*;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_INIT = 2'd1;
    localparam logic [1:0] S_DRAW = 2'd2;

    logic [1:0] state;
    coord_t xe, ye;                                // end point
    logic signed [`ER_CORDW+1:0] dx, dy, err;      // dy held negative
    logic signed [`ER_CORDW+1:0] dx_abs, dy_abs;
    logic signed [`ER_CORDW+2:0] e2;
    logic sx, sy;                                  // step up when set
    logic movx, movy;

    always_comb begin
        dx_abs = (xe > x) ? xe - x : x - xe;
        dy_abs = (ye > y) ? ye - y : y - ye;
        e2 = {err, 1'b0};
        movx = (e2 >= dy);
        movy = (e2 <= dx);
    end

    assign busy = (state != S_IDLE);
    assign valid = (state == S_DRAW);

    always_ff @(posedge clk) begin
        done <= 1'b0;
        case (state)
            S_INIT: begin
                dx <= dx_abs;
                dy <= -dy_abs;
                err <= dx_abs - dy_abs;
                sx <= (x < xe);
                sy <= (y < ye);
                state <= S_DRAW;
            end
            S_DRAW: begin
                if (x == xe && y == ye) begin
                    state <= S_IDLE;
                    done <= 1'b1;
                end else begin
                    err <= err + (movx ? dy : '0) + (movy ? dx : '0);
                    if (movx) x <= sx ? x + coord_t'(1) : x - coord_t'(1);
                    if (movy) y <= sy ? y + coord_t'(1) : y - coord_t'(1);
                end
            end
            default: begin
                if (start) begin
                    x <= x0;
                    y <= y0;
                    xe <= x1;
                    ye <= y1;
                    state <= S_INIT;
                end
            end
        endcase
        if (rst) begin
            state <= S_IDLE;
            done <= 1'b0;
        end
    end

endmodule

//--- verilog/fline_draw.sv
// horizontal span engine
// steps x from the lower to the higher end, one pixel per cycle
`timescale 1ns/1ps
`include "earthrise_macros.svh"

module fline_draw (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  earthrise_pkg::coord_t x0,
    input  earthrise_pkg::coord_t x1,
    output earthrise_pkg::coord_t x,
    output logic valid,
    output logic done
);
    import earthrise_pkg::*;

    coord_t xe;  // last x of the span

    always_ff @(posedge clk) begin
        done <= 1'b0;
        if (start) begin
            x <= (x0 < x1) ? x0 : x1;
            xe <= (x0 < x1) ? x1 : x0;
            valid <= 1'b1;
        end else if (valid) begin
            if (x == xe) begin
                valid <= 1'b0;
                done <= 1'b1;  // after the last pixel
            end else begin
                x <= x + coord_t'(1);
            end
        end
        if (rst) begin
            valid <= 1'b0;
            done <= 1'b0;
        end
    end

endmodule

//--- verilog/pixel_write.sv
// pixel write path: canvas clip, pixel index, word address and pixel id
// in three stages, then write mask and data packed by bits per pixel
`timescale 1ns/1ps
`include "earthrise_macros.svh"

module pixel_write (
    input  logic clk,
    input  logic rst,
    input  logic drawing,
    input  earthrise_pkg::coord_t x,
    input  earthrise_pkg::coord_t y,
    input  earthrise_pkg::colr_t colr,
    input  earthrise_pkg::coord_t canv_w,
    input  earthrise_pkg::coord_t canv_h,
    input  logic [7:0] canv_bpp,
    input  logic [`ER_VRAM_ADDRW-1:0] addr_base,
    input  logic [`ER_SHIFTW-1:0] addr_shift,
    output logic [`ER_VRAM_ADDRW-1:0] vram_addr,
    output logic [`ER_WORD-1:0] vram_din,
    output logic [`ER_WORD-1:0] vram_wmask
);
    import earthrise_pkg::*;

    localparam int W = `ER_WORD;
    localparam int AW = `ER_VRAM_ADDRW;
    localparam int IDW = $clog2(`ER_WORD);
    localparam int IW = 2 * `ER_CORDW;  // pixel index

    logic [`ER_WR_LAT-1:0] we;    // write enable, oldest at top
    logic [`ER_WR_LAT-1:0] clip;
    colr_t colr_1, colr_2, colr_3;
    coord_t x_1;
    logic [IW-1:0] idx_y, idx;
    logic [IDW-1:0] pix_id;
    logic [3:0] bpp;              // effective bits per pixel
    logic [7:0] sh;               // bit offset in word
    logic [W-1:0] field;

    always_ff @(posedge clk) begin
        we <= {we[`ER_WR_LAT-2:0], drawing};
        clip <= {clip[`ER_WR_LAT-2:0], (x < 0 || x >= canv_w || y < 0 || y >= canv_h)};
        colr_1 <= colr;
        colr_2 <= colr_1;
        colr_3 <= colr_2;
        idx_y <= y * canv_w;  // stage 1
        x_1 <= x;
        idx <= idx_y + IW'(x_1);  // stage 2
        vram_addr <= addr_base + AW'(idx >> addr_shift);  // stage 3
        pix_id <= idx[IDW-1:0] & ((IDW'(1) << addr_shift) - IDW'(1));
        if (rst) we <= '0;
    end

    always_comb begin
        case (canv_bpp)
            8'd1, 8'd2, 8'd8: bpp = canv_bpp[3:0];
            default: bpp = 4'd4;
        endcase
        field = (W'(1) << bpp) - W'(1);
        sh = pix_id * bpp;
        vram_wmask = (we[`ER_WR_LAT-1] && !clip[`ER_WR_LAT-1]) ? field << sh : '0;
        vram_din = (W'(colr_3) & field) << sh;
    end

endmodule

//--- verilog/earthrise.sv
// Earthrise graphics engine top
// controller, line and span engines, pixel write path
`timescale 1ns/1ps
`include "earthrise_macros.svh"

module earthrise (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  earthrise_pkg::coord_t canv_w,
    input  earthrise_pkg::coord_t canv_h,
    input  logic [7:0] canv_bpp,
    input  logic [`ER_WORD-1:0] cmd_list,
    input  logic [`ER_VRAM_ADDRW-1:0] addr_base,
    input  logic [`ER_SHIFTW-1:0] addr_shift,
    output logic [`ER_CMD_ADDRW+1:0] pc,
    output logic [`ER_VRAM_ADDRW-1:0] vram_addr,
    output logic [`ER_WORD-1:0] vram_din,
    output logic [`ER_WORD-1:0] vram_wmask,
    output logic busy,
    output logic done,
    output logic instr_invalid
);
    import earthrise_pkg::*;

    logic line_start, line_valid, line_done;
    coord_t line_x0, line_y0, line_x1, line_y1;
    coord_t line_x, line_y;
    logic span_start, span_valid, span_done;
    coord_t span_x0, span_x1, span_x;
    logic drawing;  // one pixel per cycle
    coord_t x, y;
    colr_t colr;

    earthrise_ctrl ctrl_inst (.*);

    line_draw line_inst (
        .clk(clk),
        .rst(rst),
        .start(line_start),
        .x0(line_x0),
        .y0(line_y0),
        .x1(line_x1),
        .y1(line_y1),
        .x(line_x),
        .y(line_y),
        .valid(line_valid),
        .busy(),
        .done(line_done)
    );

    fline_draw span_inst (
        .clk(clk),
        .rst(rst),
        .start(span_start),
        .x0(span_x0),
        .x1(span_x1),
        .x(span_x),
        .valid(span_valid),
        .done(span_done)
    );

    pixel_write pixel_write_inst (.*);

endmodule

//--- verification/earthrise_checker.sv
// pixel memory checker for the Earthrise testbench
// logs every masked write into a word image, holds the expected image,
// compares both, the write count, busy, done, pc and the invalid flag,
// keeps the test counts
`timescale 1ns/1ps
`include "earthrise_macros.svh"

module earthrise_checker (
    input logic clk,
    input logic start,
    input logic busy,
    input logic done,
    input logic instr_invalid,
    input logic [`ER_CMD_ADDRW+1:0] pc,
    input logic [`ER_VRAM_ADDRW-1:0] vram_addr,
    input logic [`ER_WORD-1:0] vram_din,
    input logic [`ER_WORD-1:0] vram_wmask
);
    localparam int DEPTH = 1 << `ER_VRAM_ADDRW;

    logic [`ER_WORD-1:0] act_data [DEPTH];
    logic [`ER_WORD-1:0] act_mask [DEPTH];  // bits written so far
    logic [`ER_WORD-1:0] exp_data [DEPTH];
    logic [`ER_WORD-1:0] exp_mask [DEPTH];
    logic inv_at_done = 1'b0;
    logic start_q = 1'b0;
    logic done_q = 1'b0;
    logic [2:0] busy_seen = 'x;                      // after start, at done, after done
    logic [`ER_CMD_ADDRW+1:0] pc_after_done = 'x;
    int done_cycles = 0;
    int exp_writes = 0;                              // one per pixel inside the canvas
    int act_writes = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    // sampled mid-cycle, the write path outputs are stable here
    always @(negedge clk) begin
        if (vram_wmask != '0) begin
            act_data[vram_addr] = (act_data[vram_addr] & ~vram_wmask)
                                | (vram_din & vram_wmask);
            act_mask[vram_addr] = act_mask[vram_addr] | vram_wmask;
            act_writes++;
        end
        if (start_q) busy_seen[2] = busy;
        if (done) begin
            inv_at_done = instr_invalid;
            busy_seen[1] = busy;
            done_cycles++;
        end
        if (done_q) begin
            busy_seen[0] = busy;
            pc_after_done = pc;
        end
        start_q = start;
        done_q = done;
    end

    task automatic clear_image();
        for (int a = 0; a < DEPTH; a++) begin
            act_data[a] = '0;
            act_mask[a] = '0;
            exp_data[a] = '0;
            exp_mask[a] = '0;
        end
        inv_at_done = 1'b0;
        busy_seen = 'x;
        pc_after_done = 'x;
        done_cycles = 0;
        exp_writes = 0;
        act_writes = 0;
    endtask

    task automatic put_expected(input int addr, input logic [`ER_WORD-1:0] data,
                                input logic [`ER_WORD-1:0] mask);
        exp_data[addr] = (exp_data[addr] & ~mask) | (data & mask);
        exp_mask[addr] = exp_mask[addr] | mask;
        exp_writes++;
    endtask

    task automatic compare_image(input string name, input logic exp_inv);
        int errs;
        errs = 0;
        for (int a = 0; a < DEPTH; a++) begin
            if (exp_mask[a] !== act_mask[a]
                    || (exp_data[a] & exp_mask[a]) !== (act_data[a] & act_mask[a])) begin
                $display("CHECK FAILED %s word %0d: expected %h mask %h, actual %h mask %h",
                         name, a, exp_data[a], exp_mask[a], act_data[a], act_mask[a]);
                errs++;
            end
        end
        if (act_writes != exp_writes) begin
            $display("CHECK FAILED %s write count: expected %0d, actual %0d",
                     name, exp_writes, act_writes);
            errs++;
        end
        if (inv_at_done !== exp_inv) begin
            $display("CHECK FAILED %s instr_invalid: expected %0d, actual %0d",
                     name, exp_inv, inv_at_done);
            errs++;
        end
        if (busy_seen !== 3'b110) begin
            $display("CHECK FAILED %s busy after start, at done, after done: expected %b, actual %b",
                     name, 3'b110, busy_seen);
            errs++;
        end
        if (done_cycles != 1) begin
            $display("CHECK FAILED %s done cycles: expected 1, actual %0d", name, done_cycles);
            errs++;
        end
        if (pc_after_done !== '0) begin
            $display("CHECK FAILED %s pc after done: expected 0, actual %0d",
                     name, pc_after_done);
            errs++;
        end
        if (errs == 0) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, errs);
            tests_failed++;
        end
    endtask

endmodule

//--- verification/earthrise_tb.sv
// testbench for the Earthrise graphics engine
// clock and reset, command memory model, test table,
// expected image model and the main test loop
`timescale 1ns/1ps
`include "earthrise_macros.svh"

module earthrise_tb;
    import earthrise_pkg::*;

    localparam int NT = 7;           // tests
    localparam int P = 20;           // half-words per program
    localparam int CANV_W = 20;
    localparam int CANV_H = 12;
    localparam int BASE = 64;        // pixel memory base word
    localparam int MAX_WAIT = 2000;  // cycles allowed until done

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic start = 1'b0;
    coord_t canv_w = coord_t'(CANV_W);
    coord_t canv_h = coord_t'(CANV_H);
    logic [7:0] canv_bpp = 8'd8;
    logic [`ER_WORD-1:0] cmd_list = '0;
    logic [`ER_VRAM_ADDRW-1:0] addr_base = `ER_VRAM_ADDRW'(BASE);
    logic [`ER_SHIFTW-1:0] addr_shift = 3'd2;
    logic [`ER_CMD_ADDRW+1:0] pc;
    logic [`ER_VRAM_ADDRW-1:0] vram_addr;
    logic [`ER_WORD-1:0] vram_din;
    logic [`ER_WORD-1:0] vram_wmask;
    logic busy, done, instr_invalid;

    logic [`ER_WORD-1:0] cmd_mem [1 << `ER_CMD_ADDRW];

    string name_tab [NT] = '{"pixel_bpp8", "pixel_bpp2", "lines_bpp4", "rects_bpp8",
                             "clip_bpp1", "jump", "invalid_op"};
    int bpp_tab [NT] = '{8, 2, 4, 8, 1, 4, 8};
    int shift_tab [NT] = '{2, 4, 3, 2, 5, 3, 2};
    bit inv_tab [NT] = '{0, 0, 0, 0, 0, 0, 1};
    logic [15:0] prog_tab [NT * P] = '{
        // pixels, translation, colour choice
        16'hC005, 16'hC10A, 16'h0003, 16'h1002, 16'hD000, 16'h8004, 16'h9001, 16'h0000,
        16'h1000, 16'hD002, 16'h0002, 16'hD003, 16'h8000, 16'h9000, 16'hCE00, 16'hCE00,
        16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00,
        16'hC006, 16'hC203, 16'h0000, 16'h1000, 16'hD000, 16'h0005, 16'hD001, 16'h000F,
        16'h100B, 16'hD000, 16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00,
        16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00,
        // horizontal, vertical, diagonal line, then a reversed span
        16'hC00C, 16'hC109, 16'h0001, 16'h1001, 16'h200A, 16'h3001, 16'hD100, 16'h1003,
        16'h3009, 16'h2001, 16'hD102, 16'h0005, 16'h200B, 16'hD100, 16'h100B, 16'h2000,
        16'hDF02, 16'hCE00, 16'hCE00, 16'hCE00,
        // outlined rect, filled rect with swapped corners
        16'hC021, 16'hC244, 16'h0002, 16'h1001, 16'h2007, 16'h3005, 16'hD400, 16'h000E,
        16'h100A, 16'h200B, 16'h3007, 16'hD401, 16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00,
        16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00,
        // partly clipped rect and pixels on each canvas edge
        16'hC0FF, 16'hC201, 16'h0FFE, 16'h1003, 16'h2002, 16'h3005, 16'hD401, 16'h0014,
        16'h1000, 16'hD000, 16'h0013, 16'h100C, 16'hD000, 16'h100B, 16'hD000, 16'h0005,
        16'h1FFF, 16'hD000, 16'hCE00, 16'hCE00,
        // jump to byte 12 over a pixel
        16'h0003, 16'h1003, 16'hA00C, 16'hCA00, 16'hD000, 16'hCE00, 16'h0009, 16'hD000,
        16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00,
        16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00,
        // opcode 5 stops the program
        16'h0001, 16'h1001, 16'hD000, 16'h5000, 16'h0002, 16'hD000, 16'hCE00, 16'hCE00,
        16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00,
        16'hCE00, 16'hCE00, 16'hCE00, 16'hCE00
    };

    // model registers, kept across programs like the engine's
    int vx0, vy0, vx1, vy1;
    int tx = 0;
    int ty = 0;
    int jt_half = 0;                                      // jump target half-word
    logic [7:0] pal [4] = '{8'd1, 8'd1, 8'd1, 8'd1};      // line A, B, fill A, B
    bit timed_out = 1'b0;

    always #5 clk = ~clk;

    always @(posedge clk) cmd_list <= cmd_mem[pc[`ER_CMD_ADDRW+1:2]];  // one cycle read

    earthrise dut (.*);

    earthrise_checker chk (.*);

    task automatic plot_pixel(input int px, input int py, input logic [7:0] c, input int t);
        int idx, b, id, addr;
        logic [31:0] field;
        if (px >= 0 && px < CANV_W && py >= 0 && py < CANV_H) begin
            idx = py * CANV_W + px;
            b = (bpp_tab[t] == 1 || bpp_tab[t] == 2 || bpp_tab[t] == 8) ? bpp_tab[t] : 4;
            id = idx % (1 << shift_tab[t]);
            field = (32'd1 << b) - 32'd1;
            addr = (BASE + (idx >> shift_tab[t])) % (1 << `ER_VRAM_ADDRW);
            chk.put_expected(addr, (c & field) << (id * b), field << (id * b));
        end
    endtask

    // straight and 45 degree segments only
    task automatic draw_segment(input int ax, input int ay, input int bx, input int by,
                                input logic [7:0] c, input int t);
        int sx, sy, n, m;
        sx = (bx > ax) ? 1 : (bx < ax) ? -1 : 0;
        sy = (by > ay) ? 1 : (by < ay) ? -1 : 0;
        n = (bx > ax) ? bx - ax : ax - bx;
        m = (by > ay) ? by - ay : ay - by;
        if (m > n) n = m;
        for (int i = 0; i <= n; i++) plot_pixel(ax + i * sx, ay + i * sy, c, t);
    endtask

    task automatic build_expected(input int t);
        int h, steps, xl, xh, yl, yh;
        logic [15:0] ins;
        logic [7:0] c;
        bit run;
        h = 0;
        steps = 0;
        run = 1'b1;
        while (run && h < P && steps < 100) begin
            ins = prog_tab[t * P + h];
            h++;
            steps++;
            case (ins[15:12])
                4'h0: vx0 = $signed(ins[11:0]) + tx;
                4'h1: vy0 = $signed(ins[11:0]) + ty;
                4'h2: vx1 = $signed(ins[11:0]) + tx;
                4'h3: vy1 = $signed(ins[11:0]) + ty;
                4'h8: tx = $signed(ins[11:0]);
                4'h9: ty = $signed(ins[11:0]);
                4'hA: jt_half = ins[7:1];
                4'hC: begin
                    case (ins[11:8])
                        4'h0, 4'h1, 4'h2, 4'h3: pal[ins[9:8]] = ins[7:0];
                        4'hA: h = jt_half;
                        4'hC: ;
                        default: run = 1'b0;  // cease or unknown function
                    endcase
                end
                4'hD: begin
                    c = pal[{ins[`ER_OPT_FILL], ins[`ER_OPT_COLR]}];
                    xl = (vx0 < vx1) ? vx0 : vx1;
                    xh = (vx0 < vx1) ? vx1 : vx0;
                    yl = (vy0 < vy1) ? vy0 : vy1;
                    yh = (vy0 < vy1) ? vy1 : vy0;
                    case (ins[11:8])
                        4'h0: plot_pixel(vx0, vy0, c, t);
                        4'h1: draw_segment(vx0, vy0, vx1, vy1, c, t);
                        4'h4: begin
                            if (ins[`ER_OPT_FILL]) begin
                                for (int yy = yl; yy <= yh; yy++)
                                    for (int xx = xl; xx <= xh; xx++) plot_pixel(xx, yy, c, t);
                            end else begin
                                draw_segment(xl, yl, xh, yl, c, t);
                                draw_segment(xl, yh, xh, yh, c, t);
                                draw_segment(xl, yl, xl, yh, c, t);
                                draw_segment(xh, yl, xh, yh, c, t);
                            end
                        end
                        4'hF: for (int xx = xl; xx <= xh; xx++) plot_pixel(xx, vy0, c, t);
                        default: run = 1'b0;
                    endcase
                end
                default: run = 1'b0;
            endcase
        end
    endtask

    task automatic load_program(input int t);
        logic [15:0] lo, hi;
        for (int w = 0; w < (1 << `ER_CMD_ADDRW); w++) begin
            lo = (2 * w < P) ? prog_tab[t * P + 2 * w] : 16'hCE00;
            hi = (2 * w + 1 < P) ? prog_tab[t * P + 2 * w + 1] : 16'hCE00;
            cmd_mem[w] = {hi, lo};  // low half at the lower byte address
        end
    endtask

    task automatic run_test(input int t);
        int n;
        load_program(t);
        chk.clear_image();
        build_expected(t);
        @(posedge clk);
        canv_bpp <= 8'(bpp_tab[t]);
        addr_shift <= 3'(shift_tab[t]);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!done && n < MAX_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("test %s: timeout, done did not arrive within %0d cycles",
                     name_tab[t], MAX_WAIT);
            timed_out = 1'b1;
        end else begin
            repeat (`ER_WR_LAT) @(negedge clk);  // last writes drain
            chk.compare_image(name_tab[t], inv_tab[t]);
        end
    endtask

    initial begin
        load_program(0);
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int t = 0; t < NT && !timed_out; t++) run_test(t);
        $display("%0d tests passed, %0d failed, %0d timed out",
                 chk.tests_passed, chk.tests_failed, timed_out);
        if (chk.tests_failed == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/earthrise_pkg.sv
verilog/earthrise_ctrl.sv
verilog/line_draw.sv
verilog/fline_draw.sv
verilog/pixel_write.sv
verilog/earthrise.sv
verification/earthrise_checker.sv
verification/earthrise_tb.sv
